/* files.f */
+incdir+dv
design/wb_pkg.sv
design/wb_result_slot.sv
design/wb_arbiter.sv
design/wb_regfile.sv
design/wb_csr_file.sv
design/wb_top.sv
dv/tb_wb_top.sv

/* Bender.yml */
package:
  name: wb_stage

sources:
  - files:
      - design/wb_pkg.sv
      - design/wb_result_slot.sv
      - design/wb_arbiter.sv
      - design/wb_regfile.sv
      - design/wb_csr_file.sv
      - design/wb_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_wb_top.sv

/* dv/wb_tb_vectors.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback testbench vector table
// rows of units, payload fields, expected
// commit order and channel of each commit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// mask, we, addr and id follow the unit order alu1, alu2, mul1, mul2, lsu, csr
// index 6 of addr and id is the second alu1 result of a busy_slot row
typedef struct {
    string       name;
    logic [5:0]  mask;
    logic [5:0]  we;
    logic [4:0]  addr [7];
    logic [3:0]  id [7];
    logic        csr_we;
    logic [11:0] csr_addr;
    logic        twice;
    int          n_exp;
    logic [3:0]  exp_id [7];
    logic [6:0]  exp_ch2;
} vec_t;

localparam int NUM_VEC = 5;

vec_t vectors [NUM_VEC] = '{
    '{"alu_single", 6'b000001, 6'b111111, '{1, 0, 0, 0, 0, 0, 0}, '{1, 0, 0, 0, 0, 0, 0},
      1'b0, 12'h000, 1'b0, 1, '{1, 0, 0, 0, 0, 0, 0}, 7'b0000000},
    '{"all_six", 6'b111111, 6'b111111, '{2, 3, 4, 5, 6, 7, 0}, '{1, 2, 3, 4, 5, 6, 0},
      1'b1, 12'h341, 1'b0, 6, '{5, 4, 3, 6, 2, 1, 0}, 7'b0101010},
    '{"no_write", 6'b000011, 6'b111110, '{8, 0, 0, 0, 0, 0, 0}, '{7, 8, 0, 0, 0, 0, 0},
      1'b0, 12'h000, 1'b0, 2, '{8, 7, 0, 0, 0, 0, 0}, 7'b0000010},
    '{"csr_unmapped", 6'b100000, 6'b111111, '{0, 0, 0, 0, 0, 9, 0}, '{0, 0, 0, 0, 0, 9, 0},
      1'b1, 12'h7C0, 1'b0, 1, '{9, 0, 0, 0, 0, 0, 0}, 7'b0000000},
    '{"busy_slot", 6'b111111, 6'b111111, '{10, 11, 12, 13, 14, 15, 10},
      '{1, 2, 3, 4, 5, 6, 10}, 1'b1, 12'h340, 1'b1, 7, '{5, 4, 3, 6, 2, 1, 10}, 7'b0101010}
};

/* dv/tb_wb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the writeback subsystem
// table driven with reference models
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_wb_top;

    `include "wb_tb_vectors.svh"

    logic                           clk;
    logic                           rst_n_i;
    logic                           req [6];
    logic                           ack [6];
    wb_pkg::gpr_result_t            gpr_pl [5];
    wb_pkg::csr_result_t            csr_pl;
    logic                           commit_valid1;
    logic                           commit_valid2;
    logic [wb_pkg::COMMIT_ID_W-1:0] commit_id1;
    logic [wb_pkg::COMMIT_ID_W-1:0] commit_id2;
    logic [wb_pkg::REG_ADDR_W-1:0]  rf_raddr1;
    logic [wb_pkg::REG_ADDR_W-1:0]  rf_raddr2;
    logic [wb_pkg::REG_DATA_W-1:0]  rf_rdata1;
    logic [wb_pkg::REG_DATA_W-1:0]  rf_rdata2;
    logic [wb_pkg::CSR_ADDR_W-1:0]  csr_raddr;
    logic [wb_pkg::REG_DATA_W-1:0]  csr_rdata;

    // reference state
    logic [31:0] exp_regs [32];
    logic [31:0] exp_scr [4];
    int          exp_total;
    logic [31:0] lfsr_state;
    int          errors;
    int          cyc;
    int          observed;
    int          commit_cyc [16];
    int          ack_cyc [7];
    logic [3:0]  got_id [$];
    bit          got_ch2 [$];
    int          got_cyc [$];

    wb_top u_wb_top (
        .clk(clk), .rst_n_i(rst_n_i),
        .alu1_req_i(req[0]), .alu1_payload_i(gpr_pl[0]), .alu1_ack_o(ack[0]),
        .alu2_req_i(req[1]), .alu2_payload_i(gpr_pl[1]), .alu2_ack_o(ack[1]),
        .mul1_req_i(req[2]), .mul1_payload_i(gpr_pl[2]), .mul1_ack_o(ack[2]),
        .mul2_req_i(req[3]), .mul2_payload_i(gpr_pl[3]), .mul2_ack_o(ack[3]),
        .lsu_req_i(req[4]), .lsu_payload_i(gpr_pl[4]), .lsu_ack_o(ack[4]),
        .csr_req_i(req[5]), .csr_payload_i(csr_pl), .csr_ack_o(ack[5]),
        .commit_valid1_o(commit_valid1), .commit_id1_o(commit_id1),
        .commit_valid2_o(commit_valid2), .commit_id2_o(commit_id2),
        .rf_raddr1_i(rf_raddr1), .rf_raddr2_i(rf_raddr2),
        .rf_rdata1_o(rf_rdata1), .rf_rdata2_o(rf_rdata2),
        .csr_raddr_i(csr_raddr), .csr_rdata_o(csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // commit outputs are combinational and stable at the falling edge
    always @(negedge clk) begin
        if (rst_n_i && commit_valid1) begin
            got_id.push_back(commit_id1);
            got_ch2.push_back(1'b0);
            got_cyc.push_back(cyc);
            commit_cyc[commit_id1] = cyc;
            observed++;
        end
        if (rst_n_i && commit_valid2) begin
            got_id.push_back(commit_id2);
            got_ch2.push_back(1'b1);
            got_cyc.push_back(cyc);
            commit_cyc[commit_id2] = cyc;
            observed++;
        end
    end

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003
                                       : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] csr_expect(logic [11:0] a);
        if (a >= 12'h340 && a <= 12'h343) begin
            return exp_scr[a - 12'h340];
        end else if (a == 12'hC02) begin
            return exp_total;
        end
        return '0;
    endfunction

    task automatic check_commit(string name, logic [wb_pkg::COMMIT_ID_W-1:0] exp,
                                logic [wb_pkg::COMMIT_ID_W-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_gpr(string name, logic [wb_pkg::REG_DATA_W-1:0] exp,
                             logic [wb_pkg::REG_DATA_W-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_csr(string name, logic [wb_pkg::REG_DATA_W-1:0] exp,
                             logic [wb_pkg::REG_DATA_W-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // producer side of the four-phase handshake up to the drop of req
    task automatic handshake(input int u, input int slot);
        int waited;
        waited = 0;
        @(posedge clk);
        req[u] <= 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack[u] && waited < 30);
        if (!ack[u]) begin
            errors++;
            $display("unit %0d never acknowledged its request", u);
        end
        ack_cyc[slot] = cyc;
        @(posedge clk);
        req[u] <= 1'b0;
    endtask

    task automatic run_vector(input vec_t v);
        logic [31:0] data [7];
        logic [31:0] csr_data;
        logic [11:0] rd_list [6];
        int          tries;
        int          n_burst;
        int          step;
        for (int u = 0; u < 7; u++) begin
            data[u] = rand_bits(32);
        end
        csr_data = rand_bits(32);
        got_id.delete();
        got_ch2.delete();
        got_cyc.delete();

        // reference model of the register and csr files
        for (int u = 0; u < 6; u++) begin
            if (v.mask[u] && v.we[u] && v.addr[u] != 0) exp_regs[v.addr[u]] = data[u];
        end
        if (v.twice && v.we[0] && v.addr[6] != 0) exp_regs[v.addr[6]] = data[6];
        if (v.mask[5] && v.csr_we && v.csr_addr >= 12'h340 && v.csr_addr <= 12'h343) begin
            exp_scr[v.csr_addr - 12'h340] = csr_data;
        end
        exp_total += v.n_exp;

        @(posedge clk);
        for (int u = 0; u < 5; u++) begin
            gpr_pl[u] <= '{v.we[u], v.addr[u], data[u], v.id[u]};
        end
        csr_pl <= '{'{v.we[5], v.addr[5], data[5], v.id[5]}, v.csr_we, v.csr_addr, csr_data};

        fork
            if (v.mask[0]) begin
                handshake(0, 0);
                if (v.twice) begin
                    // ack falls on the next edge while req rises on that same edge
                    gpr_pl[0] <= '{v.we[0], v.addr[6], data[6], v.id[6]};
                    handshake(0, 6);
                end
            end
            if (v.mask[1]) handshake(1, 1);
            if (v.mask[2]) handshake(2, 2);
            if (v.mask[3]) handshake(3, 3);
            if (v.mask[4]) handshake(4, 4);
            if (v.mask[5]) handshake(5, 5);
        join

        tries = 0;
        while (got_id.size() < v.n_exp && tries < 10) begin
            @(negedge clk);
            tries++;
        end

        rd_list = '{12'h340, 12'h341, 12'h342, 12'h343, 12'hC02, v.csr_addr};
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            rf_raddr1 <= wb_pkg::REG_ADDR_W'(i);
            rf_raddr2 <= wb_pkg::REG_ADDR_W'(i + 16);
            csr_raddr <= rd_list[i % 6];
            @(negedge clk);
            check_gpr($sformatf("%s x%0d", v.name, i), exp_regs[i], rf_rdata1);
            check_gpr($sformatf("%s x%0d", v.name, i + 16), exp_regs[i + 16], rf_rdata2);
            check_csr($sformatf("%s csr %h", v.name, rd_list[i % 6]),
                      csr_expect(rd_list[i % 6]), csr_rdata);
        end

        if (got_id.size() != v.n_exp) begin
            errors++;
            $display("FAILED %s commit count: expected %0d, actual %0d",
                     v.name, v.n_exp, got_id.size());
        end
        for (int k = 0; k < v.n_exp && k < got_id.size(); k++) begin
            check_commit($sformatf("%s commit %0d", v.name, k), v.exp_id[k], got_id[k]);
            if (got_ch2[k] != v.exp_ch2[k]) begin
                errors++;
                $display("FAILED %s commit %0d channel: expected %0d, actual %0d",
                         v.name, k, v.exp_ch2[k] + 1, got_ch2[k] + 1);
            end
        end

        // each channel 1 commit opens the next cycle of the burst
        n_burst = v.twice ? v.n_exp - 1 : v.n_exp;
        step = 0;
        for (int k = 1; k < n_burst && k < got_id.size(); k++) begin
            if (!v.exp_ch2[k]) begin
                step++;
            end
            if (got_cyc[k] != got_cyc[0] + step) begin
                errors++;
                $display("FAILED %s commit %0d cycle: expected %0d, actual %0d",
                         v.name, k, got_cyc[0] + step, got_cyc[k]);
            end
        end

        // second alu1 result must not be taken before the first one commits
        if (v.twice && ack_cyc[6] <= commit_cyc[v.id[0]] + 1) begin
            errors++;
            $display("%s: full alu1 slot accepted a second result", v.name);
        end
    endtask

    initial begin
        #((NUM_VEC * 40 + 5) * 10);
        $display("watchdog expired before all vectors completed");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n_i    = 1'b0;
        req        = '{default: 1'b0};
        gpr_pl     = '{default: '0};
        csr_pl     = '0;
        rf_raddr1  = '0;
        rf_raddr2  = '0;
        csr_raddr  = '0;
        exp_regs   = '{default: '0};
        exp_scr    = '{default: '0};
        exp_total  = 0;
        lfsr_state = 32'hdde9;
        errors     = 0;
        cyc        = 0;
        observed   = 0;
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int r = 0; r < NUM_VEC; r++) begin
            // idle gap between rows
            repeat (rand_bits(3)) @(posedge clk);
            run_vector(vectors[r]);
        end

        $display("errors: %0d, commits observed: %0d", errors, observed);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* design/wb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback subsystem top
// six result slots, arbiter, gpr and csr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wb_top (
    input  logic                           clk,
    input  logic                           rst_n_i,

    // execution unit producers
    input  logic                           alu1_req_i,
    input  wb_pkg::gpr_result_t            alu1_payload_i,
    output logic                           alu1_ack_o,
    input  logic                           alu2_req_i,
    input  wb_pkg::gpr_result_t            alu2_payload_i,
    output logic                           alu2_ack_o,
    input  logic                           mul1_req_i,
    input  wb_pkg::gpr_result_t            mul1_payload_i,
    output logic                           mul1_ack_o,
    input  logic                           mul2_req_i,
    input  wb_pkg::gpr_result_t            mul2_payload_i,
    output logic                           mul2_ack_o,
    input  logic                           lsu_req_i,
    input  wb_pkg::gpr_result_t            lsu_payload_i,
    output logic                           lsu_ack_o,
    input  logic                           csr_req_i,
    input  wb_pkg::csr_result_t            csr_payload_i,
    output logic                           csr_ack_o,

    // commit
    output logic                           commit_valid1_o,
    output logic [wb_pkg::COMMIT_ID_W-1:0] commit_id1_o,
    output logic                           commit_valid2_o,
    output logic [wb_pkg::COMMIT_ID_W-1:0] commit_id2_o,

    // observation read ports
    input  logic [wb_pkg::REG_ADDR_W-1:0]  rf_raddr1_i,
    input  logic [wb_pkg::REG_ADDR_W-1:0]  rf_raddr2_i,
    output logic [wb_pkg::REG_DATA_W-1:0]  rf_rdata1_o,
    output logic [wb_pkg::REG_DATA_W-1:0]  rf_rdata2_o,
    input  logic [wb_pkg::CSR_ADDR_W-1:0]  csr_raddr_i,
    output logic [wb_pkg::REG_DATA_W-1:0]  csr_rdata_o
);

    logic [wb_pkg::NUM_EU-1:0]     slot_valid;
    logic [wb_pkg::NUM_EU-1:0]     slot_grant;
    wb_pkg::gpr_result_t           gpr_payload [wb_pkg::NUM_EU];
    wb_pkg::csr_result_t           csr_slot_payload;

    logic                          reg1_we;
    logic [wb_pkg::REG_ADDR_W-1:0] reg1_waddr;
    logic [wb_pkg::REG_DATA_W-1:0] reg1_wdata;
    logic                          reg2_we;
    logic [wb_pkg::REG_ADDR_W-1:0] reg2_waddr;
    logic [wb_pkg::REG_DATA_W-1:0] reg2_wdata;
    logic                          csr_we;
    logic [wb_pkg::CSR_ADDR_W-1:0] csr_waddr;
    logic [wb_pkg::REG_DATA_W-1:0] csr_wdata;

    // csr slot competes with its gpr part
    assign gpr_payload[wb_pkg::EU_CSR] = csr_slot_payload.gpr;

    wb_result_slot #(.payload_t(wb_pkg::gpr_result_t)) u_slot_alu1 (
        .clk, .rst_n_i,
        .eu_req_i(alu1_req_i), .eu_payload_i(alu1_payload_i), .eu_ack_o(alu1_ack_o),
        .slot_valid_o(slot_valid[wb_pkg::EU_ALU1]),
        .slot_payload_o(gpr_payload[wb_pkg::EU_ALU1]),
        .slot_grant_i(slot_grant[wb_pkg::EU_ALU1])
    );

    wb_result_slot #(.payload_t(wb_pkg::gpr_result_t)) u_slot_alu2 (
        .clk, .rst_n_i,
        .eu_req_i(alu2_req_i), .eu_payload_i(alu2_payload_i), .eu_ack_o(alu2_ack_o),
        .slot_valid_o(slot_valid[wb_pkg::EU_ALU2]),
        .slot_payload_o(gpr_payload[wb_pkg::EU_ALU2]),
        .slot_grant_i(slot_grant[wb_pkg::EU_ALU2])
    );

    wb_result_slot #(.payload_t(wb_pkg::gpr_result_t)) u_slot_mul1 (
        .clk, .rst_n_i,
        .eu_req_i(mul1_req_i), .eu_payload_i(mul1_payload_i), .eu_ack_o(mul1_ack_o),
        .slot_valid_o(slot_valid[wb_pkg::EU_MUL1]),
        .slot_payload_o(gpr_payload[wb_pkg::EU_MUL1]),
        .slot_grant_i(slot_grant[wb_pkg::EU_MUL1])
    );

    wb_result_slot #(.payload_t(wb_pkg::gpr_result_t)) u_slot_mul2 (
        .clk, .rst_n_i,
        .eu_req_i(mul2_req_i), .eu_payload_i(mul2_payload_i), .eu_ack_o(mul2_ack_o),
        .slot_valid_o(slot_valid[wb_pkg::EU_MUL2]),
        .slot_payload_o(gpr_payload[wb_pkg::EU_MUL2]),
        .slot_grant_i(slot_grant[wb_pkg::EU_MUL2])
    );

    wb_result_slot #(.payload_t(wb_pkg::gpr_result_t)) u_slot_lsu (
        .clk, .rst_n_i,
        .eu_req_i(lsu_req_i), .eu_payload_i(lsu_payload_i), .eu_ack_o(lsu_ack_o),
        .slot_valid_o(slot_valid[wb_pkg::EU_LSU]),
        .slot_payload_o(gpr_payload[wb_pkg::EU_LSU]),
        .slot_grant_i(slot_grant[wb_pkg::EU_LSU])
    );

    wb_result_slot #(.payload_t(wb_pkg::csr_result_t)) u_slot_csr (
        .clk, .rst_n_i,
        .eu_req_i(csr_req_i), .eu_payload_i(csr_payload_i), .eu_ack_o(csr_ack_o),
        .slot_valid_o(slot_valid[wb_pkg::EU_CSR]),
        .slot_payload_o(csr_slot_payload),
        .slot_grant_i(slot_grant[wb_pkg::EU_CSR])
    );

    wb_arbiter u_arbiter (
        .slot_valid_i(slot_valid), .gpr_payload_i(gpr_payload),
        .csr_we_i(csr_slot_payload.csr_we),
        .csr_addr_i(csr_slot_payload.csr_waddr),
        .csr_data_i(csr_slot_payload.csr_wdata),
        .slot_grant_o(slot_grant),
        .reg1_we_o(reg1_we), .reg1_waddr_o(reg1_waddr), .reg1_wdata_o(reg1_wdata),
        .reg2_we_o(reg2_we), .reg2_waddr_o(reg2_waddr), .reg2_wdata_o(reg2_wdata),
        .commit_valid1_o, .commit_id1_o, .commit_valid2_o, .commit_id2_o,
        .csr_we_o(csr_we), .csr_waddr_o(csr_waddr), .csr_wdata_o(csr_wdata)
    );

    wb_regfile u_regfile (
        .clk, .rst_n_i,
        .we1_i(reg1_we), .waddr1_i(reg1_waddr), .wdata1_i(reg1_wdata),
        .we2_i(reg2_we), .waddr2_i(reg2_waddr), .wdata2_i(reg2_wdata),
        .raddr1_i(rf_raddr1_i), .raddr2_i(rf_raddr2_i),
        .rdata1_o(rf_rdata1_o), .rdata2_o(rf_rdata2_o)
    );

    // instret follows the commit strobes
    wb_csr_file u_csr_file (
        .clk, .rst_n_i,
        .csr_we_i(csr_we), .csr_waddr_i(csr_waddr), .csr_wdata_i(csr_wdata),
        .commit_valid1_i(commit_valid1_o), .commit_valid2_i(commit_valid2_o),
        .csr_raddr_i, .csr_rdata_o
    );

endmodule

/* design/wb_csr_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// small csr file: four scratch registers
// and the retired instruction counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wb_csr_file (
    input  logic                          clk,
    input  logic                          rst_n_i,

    // write port
    input  logic                          csr_we_i,
    input  logic [wb_pkg::CSR_ADDR_W-1:0] csr_waddr_i,
    input  logic [wb_pkg::REG_DATA_W-1:0] csr_wdata_i,

    // retire events
    input  logic                          commit_valid1_i,
    input  logic                          commit_valid2_i,

    // read port
    input  logic [wb_pkg::CSR_ADDR_W-1:0] csr_raddr_i,
    output logic [wb_pkg::REG_DATA_W-1:0] csr_rdata_o
);

    localparam int unsigned SCR_IDX_W = $clog2(wb_pkg::NUM_SCRATCH);

    logic [wb_pkg::REG_DATA_W-1:0] scratch_q [wb_pkg::NUM_SCRATCH];
    logic [wb_pkg::REG_DATA_W-1:0] instret_q;
    logic                          wr_hit;
    logic                          rd_hit;

    // scratch block is aligned, compare the upper address bits
    assign wr_hit = csr_waddr_i[wb_pkg::CSR_ADDR_W-1:SCR_IDX_W] ==
                    wb_pkg::CSR_SCRATCH_BASE[wb_pkg::CSR_ADDR_W-1:SCR_IDX_W];
    assign rd_hit = csr_raddr_i[wb_pkg::CSR_ADDR_W-1:SCR_IDX_W] ==
                    wb_pkg::CSR_SCRATCH_BASE[wb_pkg::CSR_ADDR_W-1:SCR_IDX_W];

    // unmapped and read-only targets are ignored
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < wb_pkg::NUM_SCRATCH; i++) begin
                scratch_q[i] <= '0;
            end
        end else if (csr_we_i && wr_hit) begin
            scratch_q[csr_waddr_i[SCR_IDX_W-1:0]] <= csr_wdata_i;
        end
    end

    // 0, 1 or 2 retirements per cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            instret_q <= '0;
        end else begin
            instret_q <= instret_q
                       + wb_pkg::REG_DATA_W'(commit_valid1_i)
                       + wb_pkg::REG_DATA_W'(commit_valid2_i);
        end
    end

    always_comb begin
        if (rd_hit) begin
            csr_rdata_o = scratch_q[csr_raddr_i[SCR_IDX_W-1:0]];
        end else if (csr_raddr_i == wb_pkg::CSR_INSTRET) begin
            csr_rdata_o = instret_q;
        end else begin
            csr_rdata_o = '0;
        end
    end

endmodule

/* design/wb_regfile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 general register file
// two write channels, two read ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wb_regfile (
    input  logic                          clk,
    input  logic                          rst_n_i,

    // write channels where channel 1 wins on the same address
    input  logic                          we1_i,
    input  logic [wb_pkg::REG_ADDR_W-1:0] waddr1_i,
    input  logic [wb_pkg::REG_DATA_W-1:0] wdata1_i,
    input  logic                          we2_i,
    input  logic [wb_pkg::REG_ADDR_W-1:0] waddr2_i,
    input  logic [wb_pkg::REG_DATA_W-1:0] wdata2_i,

    // read ports
    input  logic [wb_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [wb_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [wb_pkg::REG_DATA_W-1:0] rdata1_o,
    output logic [wb_pkg::REG_DATA_W-1:0] rdata2_o
);

    // no storage for x0
    logic [wb_pkg::REG_DATA_W-1:0] regs [1:wb_pkg::NUM_GPR-1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < wb_pkg::NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we2_i && waddr2_i != '0) begin
                regs[waddr2_i] <= wdata2_i;
            end
            // later assignment takes precedence
            if (we1_i && waddr1_i != '0) begin
                regs[waddr1_i] <= wdata1_i;
            end
        end
    end

    // read during write gives the old value
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* design/wb_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-channel fixed-priority writeback
// arbiter: channel muxes, commits, grants
// and the gated csr write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wb_arbiter (
    // slot contents
    input  logic [wb_pkg::NUM_EU-1:0]           slot_valid_i,
    input  wb_pkg::gpr_result_t                 gpr_payload_i [wb_pkg::NUM_EU],

    // csr part of the csr slot
    input  logic                                csr_we_i,
    input  logic [wb_pkg::CSR_ADDR_W-1:0]       csr_addr_i,
    input  logic [wb_pkg::REG_DATA_W-1:0]       csr_data_i,

    output logic [wb_pkg::NUM_EU-1:0]           slot_grant_o,

    // register file write channels
    output logic                                reg1_we_o,
    output logic [wb_pkg::REG_ADDR_W-1:0]       reg1_waddr_o,
    output logic [wb_pkg::REG_DATA_W-1:0]       reg1_wdata_o,
    output logic                                reg2_we_o,
    output logic [wb_pkg::REG_ADDR_W-1:0]       reg2_waddr_o,
    output logic [wb_pkg::REG_DATA_W-1:0]       reg2_wdata_o,

    // commit
    output logic                                commit_valid1_o,
    output logic [wb_pkg::COMMIT_ID_W-1:0]      commit_id1_o,
    output logic                                commit_valid2_o,
    output logic [wb_pkg::COMMIT_ID_W-1:0]      commit_id2_o,

    // csr file write
    output logic                                csr_we_o,
    output logic [wb_pkg::CSR_ADDR_W-1:0]       csr_waddr_o,
    output logic [wb_pkg::REG_DATA_W-1:0]       csr_wdata_o
);

    logic                ch1_valid;
    logic                ch2_valid;
    wb_pkg::eu_idx_t     ch1_idx;
    wb_pkg::eu_idx_t     ch2_idx;
    wb_pkg::gpr_result_t ch1_res;
    wb_pkg::gpr_result_t ch2_res;

    // two passes over the priority list, second one skips the first pick
    always_comb begin
        ch1_valid = 1'b0;
        ch2_valid = 1'b0;
        ch1_idx   = wb_pkg::EU_ALU1;
        ch2_idx   = wb_pkg::EU_ALU1;

        for (int p = 0; p < wb_pkg::NUM_EU; p++) begin
            if (!ch1_valid && slot_valid_i[wb_pkg::PRIO_ORDER[p]]) begin
                ch1_valid = 1'b1;
                ch1_idx   = wb_pkg::PRIO_ORDER[p];
            end
        end

        if (ch1_valid) begin
            for (int p = 0; p < wb_pkg::NUM_EU; p++) begin
                if (!ch2_valid && slot_valid_i[wb_pkg::PRIO_ORDER[p]] &&
                    wb_pkg::PRIO_ORDER[p] != ch1_idx) begin
                    ch2_valid = 1'b1;
                    ch2_idx   = wb_pkg::PRIO_ORDER[p];
                end
            end
        end
    end

    assign ch1_res = gpr_payload_i[ch1_idx];
    assign ch2_res = gpr_payload_i[ch2_idx];

    // x0 writes are dropped, the result still commits
    assign reg1_we_o    = ch1_valid && ch1_res.we && (ch1_res.waddr != '0);
    assign reg1_waddr_o = reg1_we_o ? ch1_res.waddr : '0;
    assign reg1_wdata_o = reg1_we_o ? ch1_res.wdata : '0;

    assign reg2_we_o    = ch2_valid && ch2_res.we && (ch2_res.waddr != '0);
    assign reg2_waddr_o = reg2_we_o ? ch2_res.waddr : '0;
    assign reg2_wdata_o = reg2_we_o ? ch2_res.wdata : '0;

    assign commit_valid1_o = ch1_valid;
    assign commit_id1_o    = ch1_valid ? ch1_res.commit_id : '0;
    assign commit_valid2_o = ch2_valid;
    assign commit_id2_o    = ch2_valid ? ch2_res.commit_id : '0;

    // grant exactly the slots that won a channel
    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_EU; i++) begin
            slot_grant_o[i] = (ch1_valid && ch1_idx == wb_pkg::eu_idx_t'(i)) ||
                              (ch2_valid && ch2_idx == wb_pkg::eu_idx_t'(i));
        end
    end

    // csr write only goes out together with the csr commit
    assign csr_we_o    = slot_grant_o[wb_pkg::EU_CSR] && csr_we_i;
    assign csr_waddr_o = csr_we_o ? csr_addr_i : '0;
    assign csr_wdata_o = csr_we_o ? csr_data_i : '0;

endmodule

/* design/wb_result_slot.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one-entry result holding slot
// four-phase req/ack towards the producer,
// valid held until the arbiter grants it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wb_result_slot #(
    parameter type payload_t = wb_pkg::gpr_result_t
) (
    input  logic     clk,
    input  logic     rst_n_i,

    // producer side
    input  logic     eu_req_i,
    input  payload_t eu_payload_i,
    output logic     eu_ack_o,

    // arbiter side
    output logic     slot_valid_o,
    output payload_t slot_payload_o,
    input  logic     slot_grant_i
);

    logic     ack_q;
    logic     valid_q;
    payload_t payload_q;
    logic     accept;

    // new request with the previous handshake closed and the slot empty
    assign accept = eu_req_i && !ack_q && !valid_q;

    // ack phase of the handshake
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else if (accept) begin
            ack_q <= 1'b1;
        end else if (ack_q && !eu_req_i) begin
            // producer has dropped req
            ack_q <= 1'b0;
        end
    end

    // occupancy is cleared on the granting edge
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (slot_grant_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            payload_q <= eu_payload_i;
        end
    end

    assign eu_ack_o       = ack_q;
    assign slot_valid_o   = valid_q;
    assign slot_payload_o = payload_q;

endmodule

/* design/wb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback stage shared definitions
// widths, unit indices, arbiter priority
// and the two result payload structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package wb_pkg;

    // datapath widths
    localparam int unsigned REG_DATA_W  = 32;
    localparam int unsigned REG_ADDR_W  = 5;
    localparam int unsigned CSR_ADDR_W  = 12;
    localparam int unsigned COMMIT_ID_W = 4;
    localparam int unsigned NUM_GPR     = 2 ** REG_ADDR_W;

    // execution unit ports
    localparam int unsigned NUM_EU   = 6;
    localparam int unsigned EU_IDX_W = $clog2(NUM_EU);

    typedef logic [EU_IDX_W-1:0] eu_idx_t;

    localparam eu_idx_t EU_ALU1 = 3'd0;
    localparam eu_idx_t EU_ALU2 = 3'd1;
    localparam eu_idx_t EU_MUL1 = 3'd2;
    localparam eu_idx_t EU_MUL2 = 3'd3;
    localparam eu_idx_t EU_LSU  = 3'd4;
    localparam eu_idx_t EU_CSR  = 3'd5;

    // highest priority first
    localparam eu_idx_t PRIO_ORDER [NUM_EU] = '{EU_LSU, EU_MUL2, EU_MUL1,
                                                 EU_CSR, EU_ALU2, EU_ALU1};

    // csr map
    localparam int unsigned NUM_SCRATCH = 4;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH_BASE = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRET      = 12'hC02;

    // 42 bits
    typedef struct packed {
        logic                   we;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [REG_DATA_W-1:0]  wdata;
        logic [COMMIT_ID_W-1:0] commit_id;
    } gpr_result_t;

    // 87 bits holding the gpr part and the csr write
    typedef struct packed {
        gpr_result_t           gpr;
        logic                  csr_we;
        logic [CSR_ADDR_W-1:0] csr_waddr;
        logic [REG_DATA_W-1:0] csr_wdata;
    } csr_result_t;

endpackage
